// ==== design/gat_params.svh ====
`ifndef GAT_PARAMS_SVH
`define GAT_PARAMS_SVH

// ==========================================================================
// Layer dimensions
// ==========================================================================

// Elements in one input feature row
`define GAT_NUM_FEATURE_IN   8

// Columns of W, also the length of each attention half
`define GAT_NUM_FEATURE_OUT  4

// ==========================================================================
// Data widths
// ==========================================================================

// Features, weights and attention entries
`define GAT_DATA_WIDTH       8

// One Wh element, room for 8 signed 16-bit products
`define GAT_WH_WIDTH         20

// Attention logit
`define GAT_SCORE_WIDTH      32

// ==========================================================================
// Memory sizing
// ==========================================================================

`define GAT_MAX_NODES        8
`define GAT_MAX_SUBGRAPHS    16

// 16 subgraphs x 8 nodes x 8 features
`define GAT_FEAT_DEPTH       1024

// Negative slope of the LeakyReLU as a right shift
`define GAT_LRELU_SHIFT      3

`endif

// ==== design/gat_pkg.sv ====
`include "gat_params.svh"

package gat_pkg;

  // ========================================================================
  // Datapath words
  // ========================================================================

  // Feature, weight or attention entry
  typedef logic signed [`GAT_DATA_WIDTH-1:0] feat_t;

  // Single projected element
  typedef logic signed [`GAT_WH_WIDTH-1:0] wh_elem_t;

  // One projected row, index is the output column
  typedef wh_elem_t [`GAT_NUM_FEATURE_OUT-1:0] wh_row_t;

  typedef logic signed [`GAT_SCORE_WIDTH-1:0] score_t;

  // ========================================================================
  // Counters and addresses
  // ========================================================================

  // Holds 1 .. MAX_NODES
  typedef logic [$clog2(`GAT_MAX_NODES+1)-1:0] node_cnt_t;

  typedef logic [$clog2(`GAT_NUM_FEATURE_IN)-1:0] feat_idx_t;
  typedef logic [$clog2(`GAT_FEAT_DEPTH)-1:0]     feat_addr_t;
  typedef logic [$clog2(`GAT_MAX_SUBGRAPHS)-1:0]  sg_addr_t;

  // ========================================================================
  // Static coefficients
  // ========================================================================

  // wgt[col][feature index]
  typedef feat_t [`GAT_NUM_FEATURE_OUT-1:0][`GAT_NUM_FEATURE_IN-1:0] wgt_mat_t;

  // One half of the attention vector
  typedef feat_t [`GAT_NUM_FEATURE_OUT-1:0] attn_vec_t;

endpackage

// ==== design/bram_sdp.sv ====
module bram_sdp #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 16
) (
  input  logic                     clk,

  // Write side
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  payload_t                 wdata,

  // Read side, data one cycle after the address
  input  logic [$clog2(DEPTH)-1:0] raddr,
  output payload_t                 rdata
);

  // Storage array, contents undefined until written
  payload_t mem [DEPTH];

  // ==========================================================================
  // Write port
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // ==========================================================================
  // Registered read port
  // ==========================================================================

  // Read during write of the same address returns the old word
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

// ==== design/feature_fetch.sv ====
`include "gat_params.svh"

module feature_fetch (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  input  gat_pkg::sg_addr_t   num_subgraphs,
  output gat_pkg::sg_addr_t   cnt_raddr,
  input  gat_pkg::node_cnt_t  cnt_rdata,
  output gat_pkg::feat_addr_t feat_raddr,
  output logic                busy,
  output logic                fetch_vld,
  output gat_pkg::feat_idx_t  feat_idx,
  output logic                last_feat,
  output logic                src_flag,
  output logic                sg_last,
  output gat_pkg::node_cnt_t  num_node
);
  import gat_pkg::*;

  localparam feat_idx_t LAST_IDX = feat_idx_t'(`GAT_NUM_FEATURE_IN - 1);

  logic       pref_q;
  logic       run_q;
  logic       sg_first_q;
  sg_addr_t   num_sg_q;
  sg_addr_t   last_sg;
  sg_addr_t   sg_q;
  sg_addr_t   cnt_ptr_q;
  node_cnt_t  node_q;
  node_cnt_t  nodes_q;
  node_cnt_t  cur_nodes;
  node_cnt_t  last_node;
  feat_idx_t  fidx_q;
  feat_addr_t faddr_q;
  logic       at_last_feat;
  logic       at_last_node;
  logic       at_last_sg;

  // Count comes straight from memory on the first cycle of a subgraph
  assign cur_nodes    = sg_first_q ? cnt_rdata : nodes_q;
  assign last_node    = cur_nodes - 1'b1;
  // A count of 0 wraps to the full 16 subgraphs
  assign last_sg      = num_sg_q - 1'b1;
  assign at_last_feat = (fidx_q == LAST_IDX);
  assign at_last_node = (node_q == last_node);
  assign at_last_sg   = (sg_q == last_sg);

  assign busy       = pref_q | run_q;
  assign cnt_raddr  = cnt_ptr_q;
  assign feat_raddr = faddr_q;

  // ==========================================================================
  // Nested walk over subgraphs, nodes and features
  // ==========================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pref_q     <= 1'b0;
      run_q      <= 1'b0;
      sg_first_q <= 1'b0;
      num_sg_q   <= '0;
      sg_q       <= '0;
      cnt_ptr_q  <= '0;
      node_q     <= '0;
      nodes_q    <= '0;
      fidx_q     <= '0;
      faddr_q    <= '0;
    end else if (start && !busy) begin
      // Prefetch cycle reads count 0
      pref_q     <= 1'b1;
      sg_first_q <= 1'b1;
      num_sg_q   <= num_subgraphs;
      sg_q       <= '0;
      cnt_ptr_q  <= '0;
      node_q     <= '0;
      fidx_q     <= '0;
      faddr_q    <= '0;
    end else if (pref_q) begin
      pref_q <= 1'b0;
      run_q  <= 1'b1;
    end else if (run_q) begin
      faddr_q    <= faddr_q + 1'b1;
      sg_first_q <= 1'b0;
      // Latch this count, point the count memory at the next subgraph
      if (sg_first_q) begin
        nodes_q   <= cnt_rdata;
        cnt_ptr_q <= sg_q + 1'b1;
      end
      if (at_last_feat) begin
        fidx_q <= '0;
        if (at_last_node) begin
          node_q <= '0;
          if (at_last_sg) begin
            run_q <= 1'b0;
          end else begin
            sg_q       <= sg_q + 1'b1;
            sg_first_q <= 1'b1;
          end
        end else begin
          node_q <= node_q + 1'b1;
        end
      end else begin
        fidx_q <= fidx_q + 1'b1;
      end
    end
  end

  // ==========================================================================
  // Side information, one cycle late to meet the read data
  // ==========================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_vld <= 1'b0;
    end else begin
      fetch_vld <= run_q;
    end
  end

  always_ff @(posedge clk) begin
    feat_idx  <= fidx_q;
    last_feat <= at_last_feat;
    src_flag  <= (node_q == '0);
    sg_last   <= at_last_node;
    num_node  <= cur_nodes;
  end

endmodule

// ==== design/wh_mac.sv ====
`include "gat_params.svh"

module wh_mac (
  input  logic               clk,
  input  logic               rst_n,

  // Feature element stream with aligned tags
  input  logic               fetch_vld,
  input  gat_pkg::feat_t     feat_rdata,
  input  gat_pkg::feat_idx_t feat_idx,
  input  logic               last_feat,
  input  logic               src_flag,
  input  logic               sg_last,
  input  gat_pkg::node_cnt_t num_node,

  // Static weight matrix
  input  gat_pkg::wgt_mat_t  wgt,

  // Finished projection row
  output logic               wh_vld,
  output gat_pkg::wh_row_t   wh_row,
  output logic               wh_src,
  output logic               wh_sg_last,
  output gat_pkg::node_cnt_t wh_num_node
);
  import gat_pkg::*;

  wh_row_t prod;
  wh_row_t acc_q;
  wh_row_t acc_d;

  // ==========================================================================
  // One MAC per output column
  // ==========================================================================

  // Index 0 restarts the sum, so a new node needs no bubble
  always_comb begin
    for (int c = 0; c < `GAT_NUM_FEATURE_OUT; c++) begin
      prod[c]  = wh_elem_t'(feat_rdata) * wh_elem_t'($signed(wgt[c][feat_idx]));
      acc_d[c] = (feat_idx == '0) ? prod[c] : acc_q[c] + prod[c];
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_vld) begin
      acc_q <= acc_d;
    end
  end

  // ==========================================================================
  // Row output
  // ==========================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wh_vld <= 1'b0;
    end else begin
      wh_vld <= fetch_vld & last_feat;
    end
  end

  // Capture the completed sum, including the last product
  always_ff @(posedge clk) begin
    if (fetch_vld && last_feat) begin
      wh_row      <= acc_d;
      wh_src      <= src_flag;
      wh_sg_last  <= sg_last;
      wh_num_node <= num_node;
    end
  end

endmodule

// ==== design/attn_score.sv ====
`include "gat_params.svh"

module attn_score (
  input  logic                clk,
  input  logic                rst_n,

  // Projected rows from the MAC stage
  input  logic                wh_vld,
  input  gat_pkg::wh_row_t    wh_row,
  input  logic                wh_src,
  input  logic                wh_sg_last,

  // Attention vector halves
  input  gat_pkg::attn_vec_t  attn_src,
  input  gat_pkg::attn_vec_t  attn_nbr,

  output logic                score_vld,
  output gat_pkg::score_t     score,
  output logic                score_src,
  output logic                score_sg_last
);
  import gat_pkg::*;

  score_t src_dot;
  score_t nbr_dot;

  logic   s1_vld;
  score_t s1_src_dot;
  score_t s1_nbr_dot;
  logic   s1_src;
  logic   s1_sg_last;

  score_t src_hold;
  score_t src_term;
  score_t sum;

  // ==========================================================================
  // Stage 1, both dot products of the row
  // ==========================================================================

  always_comb begin
    src_dot = '0;
    nbr_dot = '0;
    for (int c = 0; c < `GAT_NUM_FEATURE_OUT; c++) begin
      src_dot = src_dot + score_t'($signed(attn_src[c])) * score_t'($signed(wh_row[c]));
      nbr_dot = nbr_dot + score_t'($signed(attn_nbr[c])) * score_t'($signed(wh_row[c]));
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld <= 1'b0;
    end else begin
      s1_vld <= wh_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (wh_vld) begin
      s1_src_dot <= src_dot;
      s1_nbr_dot <= nbr_dot;
      s1_src     <= wh_src;
      s1_sg_last <= wh_sg_last;
    end
  end

  // ==========================================================================
  // Stage 2, source term plus neighbour term, then LeakyReLU
  // ==========================================================================

  // Source row uses its own term before the hold register catches it
  assign src_term = s1_src ? s1_src_dot : src_hold;
  assign sum      = src_term + s1_nbr_dot;

  // Kept for the rest of the subgraph
  always_ff @(posedge clk) begin
    if (s1_vld && s1_src) begin
      src_hold <= s1_src_dot;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      score_vld <= 1'b0;
    end else begin
      score_vld <= s1_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_vld) begin
      score         <= sum[`GAT_SCORE_WIDTH-1] ? (sum >>> `GAT_LRELU_SHIFT) : sum;
      score_src     <= s1_src;
      score_sg_last <= s1_sg_last;
    end
  end

endmodule

// ==== design/gat_layer_top.sv ====
`include "gat_params.svh"

module gat_layer_top (
  input  logic                clk,
  input  logic                rst_n,

  // Feature memory load
  input  logic                feat_we,
  input  gat_pkg::feat_addr_t feat_waddr,
  input  gat_pkg::feat_t      feat_wdata,

  // Node-count memory load
  input  logic                cnt_we,
  input  gat_pkg::sg_addr_t   cnt_waddr,
  input  gat_pkg::node_cnt_t  cnt_wdata,

  // Static coefficients
  input  gat_pkg::wgt_mat_t   wgt,
  input  gat_pkg::attn_vec_t  attn_src,
  input  gat_pkg::attn_vec_t  attn_nbr,

  // Run control
  input  logic                start,
  input  gat_pkg::sg_addr_t   num_subgraphs,
  output logic                busy,

  // Projection results
  output logic                wh_vld,
  output gat_pkg::wh_row_t    wh_row,
  output gat_pkg::node_cnt_t  wh_num_node,

  // Attention logits
  output logic                score_vld,
  output gat_pkg::score_t     score,
  output logic                score_src,
  output logic                score_sg_last
);
  import gat_pkg::*;

  sg_addr_t   cnt_raddr;
  node_cnt_t  cnt_rdata;
  feat_addr_t feat_raddr;
  feat_t      feat_rdata;

  logic       fetch_vld;
  feat_idx_t  feat_idx;
  logic       last_feat;
  logic       src_flag;
  logic       sg_last;
  node_cnt_t  num_node;

  logic       wh_src;
  logic       wh_sg_last;

  // ==========================================================================
  // On-chip memories
  // ==========================================================================

  bram_sdp #(
    .payload_t (feat_t),
    .DEPTH     (`GAT_FEAT_DEPTH)
  ) u_feat_mem (
    .clk   (clk),
    .we    (feat_we),
    .waddr (feat_waddr),
    .wdata (feat_wdata),
    .raddr (feat_raddr),
    .rdata (feat_rdata)
  );

  bram_sdp #(
    .payload_t (node_cnt_t),
    .DEPTH     (`GAT_MAX_SUBGRAPHS)
  ) u_cnt_mem (
    .clk   (clk),
    .we    (cnt_we),
    .waddr (cnt_waddr),
    .wdata (cnt_wdata),
    .raddr (cnt_raddr),
    .rdata (cnt_rdata)
  );

  // ==========================================================================
  // Fetch, projection and scoring
  // ==========================================================================

  feature_fetch u_fetch (
    .clk           (clk),
    .rst_n         (rst_n),
    .start         (start),
    .num_subgraphs (num_subgraphs),
    .cnt_raddr     (cnt_raddr),
    .cnt_rdata     (cnt_rdata),
    .feat_raddr    (feat_raddr),
    .busy          (busy),
    .fetch_vld     (fetch_vld),
    .feat_idx      (feat_idx),
    .last_feat     (last_feat),
    .src_flag      (src_flag),
    .sg_last       (sg_last),
    .num_node      (num_node)
  );

  wh_mac u_mac (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_vld   (fetch_vld),
    .feat_rdata  (feat_rdata),
    .feat_idx    (feat_idx),
    .last_feat   (last_feat),
    .src_flag    (src_flag),
    .sg_last     (sg_last),
    .num_node    (num_node),
    .wgt         (wgt),
    .wh_vld      (wh_vld),
    .wh_row      (wh_row),
    .wh_src      (wh_src),
    .wh_sg_last  (wh_sg_last),
    .wh_num_node (wh_num_node)
  );

  attn_score u_score (
    .clk           (clk),
    .rst_n         (rst_n),
    .wh_vld        (wh_vld),
    .wh_row        (wh_row),
    .wh_src        (wh_src),
    .wh_sg_last    (wh_sg_last),
    .attn_src      (attn_src),
    .attn_nbr      (attn_nbr),
    .score_vld     (score_vld),
    .score         (score),
    .score_src     (score_src),
    .score_sg_last (score_sg_last)
  );

endmodule

// ==== testbench/tb_gat_layer.sv ====
`include "gat_params.svh"

module tb_gat_layer;
  import gat_pkg::*;

  localparam int N_IN  = `GAT_NUM_FEATURE_IN;
  localparam int N_OUT = `GAT_NUM_FEATURE_OUT;

  logic       clk;
  logic       rst_n;
  logic       feat_we;
  feat_addr_t feat_waddr;
  feat_t      feat_wdata;
  logic       cnt_we;
  sg_addr_t   cnt_waddr;
  node_cnt_t  cnt_wdata;
  wgt_mat_t   wgt;
  attn_vec_t  attn_src;
  attn_vec_t  attn_nbr;
  logic       start;
  sg_addr_t   num_subgraphs;

  logic       busy;
  logic       wh_vld;
  wh_row_t    wh_row;
  node_cnt_t  wh_num_node;
  logic       score_vld;
  score_t     score;
  logic       score_src;
  logic       score_sg_last;

  // Stimulus and reference state
  logic [31:0] lfsr_state;
  feat_t       feat_img [`GAT_FEAT_DEPTH];
  feat_t       wgt_tb [N_OUT][N_IN];
  feat_t       a_src_tb [N_OUT];
  feat_t       a_nbr_tb [N_OUT];
  int          wh_int [`GAT_MAX_NODES][N_OUT];
  node_cnt_t   counts [2][`GAT_MAX_SUBGRAPHS];
  int          run_sg [2];
  int          total_nodes;
  bit          plan_ready;
  int          n_pos;
  int          n_neg;

  // Expected results in node order
  wh_row_t     exp_wh [$];
  node_cnt_t   exp_nodes [$];
  score_t      exp_score [$];
  bit          exp_src [$];
  bit          exp_last [$];
  int          wh_times [$];

  int          cycle_cnt;
  int          wh_seen;
  int          score_seen;
  int          err_wh;
  int          err_score;
  int          err_flag;
  int          err_seq;

  gat_layer_top u_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .feat_we       (feat_we),
    .feat_waddr    (feat_waddr),
    .feat_wdata    (feat_wdata),
    .cnt_we        (cnt_we),
    .cnt_waddr     (cnt_waddr),
    .cnt_wdata     (cnt_wdata),
    .wgt           (wgt),
    .attn_src      (attn_src),
    .attn_nbr      (attn_nbr),
    .start         (start),
    .num_subgraphs (num_subgraphs),
    .busy          (busy),
    .wh_vld        (wh_vld),
    .wh_row        (wh_row),
    .wh_num_node   (wh_num_node),
    .score_vld     (score_vld),
    .score         (score),
    .score_src     (score_src),
    .score_sg_last (score_sg_last)
  );

  always #4 clk = ~clk;

  // ==========================================================================
  // Random source and reference model
  // ==========================================================================

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  // Column c of the node whose features start at base
  function automatic int calc_wh(input int base, input int c);
    int sum;
    sum = 0;
    for (int f = 0; f < N_IN; f++) begin
      sum += int'(feat_img[base + f]) * int'(wgt_tb[c][f]);
    end
    return int'(wh_elem_t'(sum));
  endfunction

  // Logit of node j, source term from node 0 of the same subgraph
  function automatic score_t calc_score(input int j);
    int src_sum;
    int nbr_sum;
    int total;
    src_sum = 0;
    nbr_sum = 0;
    for (int c = 0; c < N_OUT; c++) begin
      src_sum += int'(a_src_tb[c]) * wh_int[0][c];
      nbr_sum += int'(a_nbr_tb[c]) * wh_int[j][c];
    end
    total = src_sum + nbr_sum;
    if (total < 0) begin
      total = total >>> `GAT_LRELU_SHIFT;
    end
    return score_t'(total);
  endfunction

  task automatic build_expected(input int r);
    int      base;
    int      n_nodes;
    wh_row_t row;
    score_t  sc;
    base = 0;
    for (int s = 0; s < run_sg[r]; s++) begin
      n_nodes = int'(counts[r][s]);
      for (int j = 0; j < n_nodes; j++) begin
        for (int c = 0; c < N_OUT; c++) begin
          wh_int[j][c] = calc_wh(base + j * N_IN, c);
          row[c] = wh_elem_t'(wh_int[j][c]);
        end
        sc = calc_score(j);
        if (sc < 0) begin
          n_neg++;
        end else if (sc > 0) begin
          n_pos++;
        end
        exp_wh.push_back(row);
        exp_nodes.push_back(counts[r][s]);
        exp_score.push_back(sc);
        exp_src.push_back(j == 0);
        exp_last.push_back(j == n_nodes - 1);
      end
      base += n_nodes * N_IN;
    end
  endtask

  // ==========================================================================
  // Stimulus tasks
  // ==========================================================================

  task automatic load_run(input int r);
    logic [31:0] rnd;
    int          n_feat;
    n_feat = 0;
    for (int s = 0; s < run_sg[r]; s++) begin
      n_feat += int'(counts[r][s]) * N_IN;
      cnt_we    = 1'b1;
      cnt_waddr = sg_addr_t'(s);
      cnt_wdata = counts[r][s];
      @(negedge clk);
    end
    cnt_we = 1'b0;
    // Features packed linearly from address 0
    for (int a = 0; a < n_feat; a++) begin
      draw_bits(8, rnd);
      feat_img[a] = feat_t'(rnd[7:0]);
      feat_we     = 1'b1;
      feat_waddr  = feat_addr_t'(a);
      feat_wdata  = feat_img[a];
      @(negedge clk);
    end
    feat_we = 1'b0;
  endtask

  task automatic pulse_start(input int n_sg);
    start         = 1'b1;
    num_subgraphs = sg_addr_t'(n_sg);
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic expect_level(input string name, input logic val, input logic exp);
    assert (val === exp) else begin
      err_seq++;
      $display("** Error %s: got %h expected %h", name, val, exp);
    end
  endtask

  task automatic run_layer(input int r);
    load_run(r);
    build_expected(r);
    pulse_start(run_sg[r]);
    expect_level("busy", busy, 1'b1);
    if (r == 1) begin
      // Second pulse lands mid-run and must be ignored
      repeat (5) @(negedge clk);
      expect_level("busy", busy, 1'b1);
      pulse_start(run_sg[r] + 6);
    end
    while (busy) begin
      @(negedge clk);
    end
    while (exp_score.size() != 0) begin
      @(negedge clk);
    end
  endtask

  function automatic int error_total();
    return err_wh + err_score + err_flag + err_seq;
  endfunction

  task automatic report_counts();
    $display("Errors: wh %0d, score %0d, flags %0d, sequence %0d",
             err_wh, err_score, err_flag, err_seq);
  endtask

  // ==========================================================================
  // Output comparison
  // ==========================================================================

  always @(posedge clk) begin
    wh_row_t   row_exp;
    node_cnt_t nodes_exp;
    score_t    score_exp;
    bit        src_exp;
    bit        last_exp;
    int        wh_at;
    cycle_cnt++;
    if (wh_vld) begin
      wh_seen++;
      wh_times.push_back(cycle_cnt);
      assert (exp_wh.size() != 0) else begin
        err_seq++;
        $display("wh_vld seen with no node pending at cycle %0d", cycle_cnt);
      end
      if (exp_wh.size() != 0) begin
        row_exp   = exp_wh.pop_front();
        nodes_exp = exp_nodes.pop_front();
        assert (wh_row == row_exp) else begin
          err_wh++;
          $display("** Error wh_row: got %h expected %h", wh_row, row_exp);
        end
        assert (wh_num_node == nodes_exp) else begin
          err_wh++;
          $display("** Error wh_num_node: got %h expected %h", wh_num_node, nodes_exp);
        end
      end
    end
    if (score_vld) begin
      score_seen++;
      assert (exp_score.size() != 0 && wh_times.size() != 0) else begin
        err_seq++;
        $display("score_vld seen with no node pending at cycle %0d", cycle_cnt);
      end
      if (exp_score.size() != 0 && wh_times.size() != 0) begin
        score_exp = exp_score.pop_front();
        src_exp   = exp_src.pop_front();
        last_exp  = exp_last.pop_front();
        wh_at     = wh_times.pop_front();
        assert (score == score_exp) else begin
          err_score++;
          $display("** Error score: got %h expected %h", score, score_exp);
        end
        assert (score_src == src_exp) else begin
          err_flag++;
          $display("** Error score_src: got %h expected %h", score_src, src_exp);
        end
        assert (score_sg_last == last_exp) else begin
          err_flag++;
          $display("** Error score_sg_last: got %h expected %h", score_sg_last, last_exp);
        end
        assert (cycle_cnt - wh_at == 2) else begin
          err_seq++;
          $display("score_vld came %0d cycles after its wh_vld instead of 2",
                   cycle_cnt - wh_at);
        end
      end
    end
  end

  // Watchdog sized from the drawn node counts
  initial begin
    wait (plan_ready);
    repeat (20 * total_nodes * N_IN + 200) @(posedge clk);
    $display("Timeout: the runs did not finish in time");
    report_counts();
    $display("=== FAIL ===");
    $finish;
  end

  // ==========================================================================
  // Main sequence
  // ==========================================================================

  initial begin
    logic [31:0] rnd;
    clk           = 1'b0;
    rst_n         = 1'b0;
    feat_we       = 1'b0;
    feat_waddr    = '0;
    feat_wdata    = '0;
    cnt_we        = 1'b0;
    cnt_waddr     = '0;
    cnt_wdata     = '0;
    wgt           = '0;
    attn_src      = '0;
    attn_nbr      = '0;
    start         = 1'b0;
    num_subgraphs = '0;
    lfsr_state    = 32'h8611;

    for (int c = 0; c < N_OUT; c++) begin
      for (int f = 0; f < N_IN; f++) begin
        draw_bits(8, rnd);
        wgt_tb[c][f] = feat_t'(rnd[7:0]);
        wgt[c][f]    = wgt_tb[c][f];
      end
      draw_bits(8, rnd);
      a_src_tb[c] = feat_t'(rnd[7:0]);
      attn_src[c] = a_src_tb[c];
      draw_bits(8, rnd);
      a_nbr_tb[c] = feat_t'(rnd[7:0]);
      attn_nbr[c] = a_nbr_tb[c];
    end

    // Node counts 1 .. MAX_NODES for both runs
    run_sg[0] = 5;
    run_sg[1] = 3;
    for (int r = 0; r < 2; r++) begin
      for (int s = 0; s < run_sg[r]; s++) begin
        draw_bits(3, rnd);
        counts[r][s] = node_cnt_t'(int'(rnd[2:0]) + 1);
        total_nodes += int'(counts[r][s]);
      end
    end
    plan_ready = 1'b1;

    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    expect_level("busy", busy, 1'b0);
    expect_level("wh_vld", wh_vld, 1'b0);
    expect_level("score_vld", score_vld, 1'b0);
    repeat (4) @(negedge clk);

    run_layer(0);
    run_layer(1);
    repeat (6) @(negedge clk);

    assert (wh_seen == total_nodes && score_seen == total_nodes) else begin
      err_seq++;
      $display("Saw %0d rows and %0d logits for %0d nodes", wh_seen, score_seen, total_nodes);
    end
    assert (n_pos > 0 && n_neg > 0) else begin
      err_seq++;
      $display("Logits did not cover both signs");
    end

    report_counts();
    if (error_total() == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+design
design/gat_pkg.sv
design/bram_sdp.sv
design/feature_fetch.sv
design/wh_mac.sv
design/attn_score.sv
design/gat_layer_top.sv
testbench/tb_gat_layer.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal
TOP       ?= tb_gat_layer
FILE_LIST ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
